/* Makefile */
VERILATOR ?= verilator
TOP       := tb_rv_core
FLIST     := rv_core.f
VFLAGS    := --binary --timing --assert -Wno-fatal
MDIR      := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(MDIR)

run: build
	./$(MDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || (echo "Simulation did not complete"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(MDIR) $(LOG)

/* design/alu.sv */
/*
 * Combinational integer ALU.
 * Add, subtract, logic, shifts, signed and unsigned compare, pass-through.
 */

`timescale 1ns/10ps
`default_nettype none

module alu
  import rv_pkg::*;
(
  input  alu_fn_t alu_function,
  input  word_t   operand_a,
  input  word_t   operand_b,
  output word_t   alu_result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Only the low five bits count for shifts
  assign shamt = operand_b[4:0];

  assign lt_signed   = $signed(operand_a) < $signed(operand_b);
  assign lt_unsigned = operand_a < operand_b;

  always_comb begin
    case (alu_function)
      alu_add:    alu_result = operand_a + operand_b;
      alu_sub:    alu_result = operand_a - operand_b;
      alu_sll:    alu_result = operand_a << shamt;
      alu_slt:    alu_result = {31'b0, lt_signed};
      alu_sltu:   alu_result = {31'b0, lt_unsigned};
      alu_xor:    alu_result = operand_a ^ operand_b;
      alu_srl:    alu_result = operand_a >> shamt;
      alu_sra:    alu_result = word_t'($signed(operand_a) >>> shamt);
      alu_or:     alu_result = operand_a | operand_b;
      alu_and:    alu_result = operand_a & operand_b;
      alu_pass_b: alu_result = operand_b;
      default:    alu_result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/control_unit.sv */
/*
 * Main decoder for the single-cycle core.
 * Opcode and funct fields to datapath selects, branch resolution,
 * write strobes held off during reset.
 */

`timescale 1ns/10ps
`default_nettype none

module control_unit
  import rv_pkg::*;
(
  input  logic         clock,
  input  logic         rst_n,
  input  logic [6:0]   inst_opcode,
  input  logic [2:0]   inst_funct3,
  input  logic [6:0]   inst_funct7,
  input  word_t        alu_result,
  output alu_fn_t      alu_function,
  output logic         alu_operand_a_select,
  output logic         alu_operand_b_select,
  output logic         regfile_write_enable,
  output logic         data_mem_write_enable,
  output wb_sel_t      reg_writeback_select,
  output next_pc_sel_t next_pc_select
);

  alu_fn_t arith_fn;
  alu_fn_t branch_fn;
  logic    branch_taken;
  logic    rf_we_dec;
  logic    dm_we_dec;

  // --------------------------------------------------------------------------
  // ALU function for OP / OP-IMM, funct7[5] only matters for OP sub and shifts
  // --------------------------------------------------------------------------
  always_comb begin
    case (inst_funct3)
      f3_add_sub: arith_fn = (inst_opcode == opc_op && inst_funct7[5]) ? alu_sub : alu_add;
      f3_sll:     arith_fn = alu_sll;
      f3_slt:     arith_fn = alu_slt;
      f3_sltu:    arith_fn = alu_sltu;
      f3_xor:     arith_fn = alu_xor;
      f3_srl_sra: arith_fn = inst_funct7[5] ? alu_sra : alu_srl;
      f3_or:      arith_fn = alu_or;
      default:    arith_fn = alu_and;
    endcase
  end

  // Branch compare and outcome from the ALU result
  always_comb begin
    branch_fn    = alu_sub;
    branch_taken = 1'b0;
    case (inst_funct3)
      f3_beq:  branch_taken = (alu_result == '0);
      f3_bne:  branch_taken = (alu_result != '0);
      f3_blt:  begin branch_fn = alu_slt;  branch_taken = alu_result[0];  end
      f3_bge:  begin branch_fn = alu_slt;  branch_taken = !alu_result[0]; end
      f3_bltu: begin branch_fn = alu_sltu; branch_taken = alu_result[0];  end
      f3_bgeu: begin branch_fn = alu_sltu; branch_taken = !alu_result[0]; end
      default: branch_taken = 1'b0;
    endcase
  end

  // --------------------------------------------------------------------------
  // Opcode decode, a select of 1 means pc for A and immediate for B
  // --------------------------------------------------------------------------
  always_comb begin
    alu_function         = alu_add;
    alu_operand_a_select = 1'b0;
    alu_operand_b_select = 1'b0;
    rf_we_dec            = 1'b0;
    dm_we_dec            = 1'b0;
    reg_writeback_select = wb_alu;
    next_pc_select       = pc_plus_4;
    case (inst_opcode)
      opc_op: begin
        alu_function = arith_fn;
        rf_we_dec    = 1'b1;
      end
      opc_op_imm: begin
        alu_function         = arith_fn;
        alu_operand_b_select = 1'b1;
        rf_we_dec            = 1'b1;
      end
      opc_lui: begin
        alu_function         = alu_pass_b;
        alu_operand_b_select = 1'b1;
        rf_we_dec            = 1'b1;
        reg_writeback_select = wb_imm;
      end
      opc_auipc: begin
        alu_operand_a_select = 1'b1;
        alu_operand_b_select = 1'b1;
        rf_we_dec            = 1'b1;
      end
      opc_jal: begin
        rf_we_dec            = 1'b1;
        reg_writeback_select = wb_pc_plus_4;
        next_pc_select       = pc_plus_imm;
      end
      opc_jalr: begin
        alu_operand_b_select = 1'b1;
        rf_we_dec            = 1'b1;
        reg_writeback_select = wb_pc_plus_4;
        next_pc_select       = alu_target;
      end
      opc_branch: begin
        alu_function   = branch_fn;
        next_pc_select = branch_taken ? pc_plus_imm : pc_plus_4;
      end
      opc_load: begin
        alu_operand_b_select = 1'b1;
        rf_we_dec            = 1'b1;
        reg_writeback_select = wb_mem;
      end
      opc_store: begin
        alu_operand_b_select = 1'b1;
        dm_we_dec            = 1'b1;
      end
      default: ;
    endcase
  end

  assign regfile_write_enable  = rf_we_dec && rst_n;
  assign data_mem_write_enable = dm_we_dec && rst_n;

  no_write_in_reset: assert property (
    @(posedge clock) !rst_n |-> !(data_mem_write_enable || regfile_write_enable)
  );

endmodule

`default_nettype wire

/* design/immediate_generator.sv */
/*
 * Immediate extraction for the RV32I formats I, S, B, U and J.
 * The format follows the opcode, unknown opcodes yield zero.
 */

`timescale 1ns/10ps
`default_nettype none

module immediate_generator
  import rv_pkg::*;
(
  input  word_t inst,
  output word_t immediate
);

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  // All formats take the sign from bit 31
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (inst[6:0])
      opc_op_imm,
      opc_jalr,
      opc_load:   immediate = imm_i;
      opc_store:  immediate = imm_s;
      opc_branch: immediate = imm_b;
      opc_lui,
      opc_auipc:  immediate = imm_u;
      opc_jal:    immediate = imm_j;
      default:    immediate = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/regfile.sv */
/*
 * 32 x 32-bit integer register file.
 * Two combinational read ports, one synchronous write port, x0 fixed at zero.
 */

`timescale 1ns/10ps
`default_nettype none

module regfile
  import rv_pkg::*;
(
  input  logic     clock,
  input  reg_idx_t rs1_address,
  input  reg_idx_t rs2_address,
  input  logic     write_enable,
  input  reg_idx_t rd_address,
  input  word_t    rd_data,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  word_t regs [32];

  // Writes to x0 are dropped
  always_ff @(posedge clock) begin
    if (write_enable && (rd_address != '0)) begin
      regs[rd_address] <= rd_data;
    end
  end

  // Entry 0 is never written, so force its read value
  assign rs1_data = (rs1_address == '0) ? '0 : regs[rs1_address];
  assign rs2_data = (rs2_address == '0) ? '0 : regs[rs2_address];

  // A nonzero write aimed at x0 must not show up on a later read
  x0_stays_zero: assert property (
    @(posedge clock)
    (write_enable && (rd_address == '0) && (rd_data != '0))
      |=> ((rs1_address != '0) || (rs1_data == '0))
  );

endmodule

`default_nettype wire

/* design/rv_core.sv */
/*
 * RV32I single-cycle core top level.
 * Control unit and datapath joined to the instruction and data ports.
 */

`timescale 1ns/10ps
`default_nettype none

module rv_core
  import rv_pkg::*;
(
  input  logic  clock,
  input  logic  rst_n,
  output word_t pc,
  input  word_t inst,
  output word_t data_mem_address,
  output word_t data_mem_write_data,
  output logic  data_mem_write_enable,
  input  word_t data_mem_read_data
);

  alu_fn_t      alu_function;
  logic         alu_operand_a_select;
  logic         alu_operand_b_select;
  logic         regfile_write_enable;
  wb_sel_t      reg_writeback_select;
  next_pc_sel_t next_pc_select;
  logic [6:0]   inst_opcode;
  logic [2:0]   inst_funct3;
  logic [6:0]   inst_funct7;
  word_t        alu_result;
  word_t        rs2_data;

  // Loads and stores address memory with the ALU sum
  assign data_mem_address    = alu_result;
  assign data_mem_write_data = rs2_data;

  control_unit u_control (
    .clock                 (clock),
    .rst_n                 (rst_n),
    .inst_opcode           (inst_opcode),
    .inst_funct3           (inst_funct3),
    .inst_funct7           (inst_funct7),
    .alu_result            (alu_result),
    .alu_function          (alu_function),
    .alu_operand_a_select  (alu_operand_a_select),
    .alu_operand_b_select  (alu_operand_b_select),
    .regfile_write_enable  (regfile_write_enable),
    .data_mem_write_enable (data_mem_write_enable),
    .reg_writeback_select  (reg_writeback_select),
    .next_pc_select        (next_pc_select)
  );

  singlecycle_datapath u_datapath (
    .clock                (clock),
    .rst_n                (rst_n),
    .inst                 (inst),
    .alu_function         (alu_function),
    .alu_operand_a_select (alu_operand_a_select),
    .alu_operand_b_select (alu_operand_b_select),
    .regfile_write_enable (regfile_write_enable),
    .data_mem_read_data   (data_mem_read_data),
    .reg_writeback_select (reg_writeback_select),
    .next_pc_select       (next_pc_select),
    .pc                   (pc),
    .rs2_data             (rs2_data),
    .inst_opcode          (inst_opcode),
    .inst_funct3          (inst_funct3),
    .inst_funct7          (inst_funct7),
    .alu_result           (alu_result)
  );

endmodule

`default_nettype wire

/* design/rv_pkg.sv */
/*
 * Shared definitions for the RV32I single-cycle core.
 * Word and register-index types, datapath select encodings,
 * ALU function codes, opcode and funct3 constants.
 */

`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_fn_t;

  // alu_target is the ALU result with bit 0 cleared (JALR)
  typedef enum logic [1:0] {
    pc_plus_4, pc_plus_imm, alu_target
  } next_pc_sel_t;

  typedef enum logic [1:0] {
    wb_alu, wb_mem, wb_pc_plus_4, wb_imm
  } wb_sel_t;

  // --------------------------------------------------------------------------
  // Major opcodes
  // --------------------------------------------------------------------------
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;

  // Branch conditions
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // OP and OP-IMM functions
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  localparam word_t initial_pc = 32'h0000_0000;
  // addi x0, x0, 0
  localparam word_t nop_inst   = 32'h0000_0013;

endpackage

`default_nettype wire

/* design/singlecycle_datapath.sv */
/*
 * Single-cycle datapath.
 * Program counter, next-pc select, operand and writeback selects,
 * field slicing, register file, ALU and immediate generator.
 */

`timescale 1ns/10ps
`default_nettype none

module singlecycle_datapath
  import rv_pkg::*;
(
  input  logic         clock,
  input  logic         rst_n,
  input  word_t        inst,
  input  alu_fn_t      alu_function,
  input  logic         alu_operand_a_select,
  input  logic         alu_operand_b_select,
  input  logic         regfile_write_enable,
  input  word_t        data_mem_read_data,
  input  wb_sel_t      reg_writeback_select,
  input  next_pc_sel_t next_pc_select,
  output word_t        pc,
  output word_t        rs2_data,
  output logic [6:0]   inst_opcode,
  output logic [2:0]   inst_funct3,
  output logic [6:0]   inst_funct7,
  output word_t        alu_result
);

  reg_idx_t rd_idx;
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  word_t    rs1_data;
  word_t    immediate;
  word_t    operand_a;
  word_t    operand_b;
  word_t    pc_incr;
  word_t    pc_offset;
  word_t    pc_next;
  word_t    rd_data;

  // --------------------------------------------------------------------------
  // Instruction fields
  // --------------------------------------------------------------------------
  assign inst_opcode = inst[6:0];
  assign rd_idx      = inst[11:7];
  assign inst_funct3 = inst[14:12];
  assign rs1_idx     = inst[19:15];
  assign rs2_idx     = inst[24:20];
  assign inst_funct7 = inst[31:25];

  // --------------------------------------------------------------------------
  // Program counter
  // --------------------------------------------------------------------------
  assign pc_incr   = pc + 32'd4;
  assign pc_offset = pc + immediate;

  always_comb begin
    case (next_pc_select)
      pc_plus_imm: pc_next = pc_offset;
      alu_target:  pc_next = {alu_result[31:1], 1'b0};
      default:     pc_next = pc_incr;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      pc <= initial_pc;
    end else begin
      pc <= pc_next;
    end
  end

  // Operand selects
  assign operand_a = alu_operand_a_select ? pc : rs1_data;
  assign operand_b = alu_operand_b_select ? immediate : rs2_data;

  // Writeback value
  always_comb begin
    case (reg_writeback_select)
      wb_mem:       rd_data = data_mem_read_data;
      wb_pc_plus_4: rd_data = pc_incr;
      wb_imm:       rd_data = immediate;
      default:      rd_data = alu_result;
    endcase
  end

  regfile u_regfile (
    .clock        (clock),
    .rs1_address  (rs1_idx),
    .rs2_address  (rs2_idx),
    .write_enable (regfile_write_enable),
    .rd_address   (rd_idx),
    .rd_data      (rd_data),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  alu u_alu (
    .alu_function (alu_function),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .alu_result   (alu_result)
  );

  immediate_generator u_imm_gen (
    .inst      (inst),
    .immediate (immediate)
  );

  // Fetch address stays on a word boundary
  pc_word_aligned: assert property (
    @(posedge clock) disable iff (!rst_n) pc[1:0] == 2'b00
  );

endmodule

`default_nettype wire

/* rv_core.f */
+incdir+testbench
design/rv_pkg.sv
design/regfile.sv
design/alu.sv
design/immediate_generator.sv
design/control_unit.sv
design/singlecycle_datapath.sv
design/rv_core.sv
testbench/tb_rv_core.sv

/* testbench/rv_asm.svh */
/*
 * Instruction encoders for building RV32I test programs.
 * R, I, S, B, U and J formats plus load and store word shorthands.
 */

`ifndef rv_asm_svh
`define rv_asm_svh

function automatic word_t r_type(input logic [6:0] funct7, input reg_idx_t rs2,
                                 input reg_idx_t rs1, input logic [2:0] funct3,
                                 input reg_idx_t rd, input logic [6:0] opcode);
  return {funct7, rs2, rs1, funct3, rd, opcode};
endfunction

function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                 input logic [2:0] funct3, input reg_idx_t rd,
                                 input logic [6:0] opcode);
  return {imm, rs1, funct3, rd, opcode};
endfunction

function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                 input reg_idx_t rs1, input logic [2:0] funct3);
  return {imm[11:5], rs2, rs1, funct3, imm[4:0], opc_store};
endfunction

// Offset is in bytes, bit 0 is dropped by the format
function automatic word_t b_type(input logic [12:0] imm, input reg_idx_t rs2,
                                 input reg_idx_t rs1, input logic [2:0] funct3);
  return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], opc_branch};
endfunction

function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                 input logic [6:0] opcode);
  return {imm, rd, opcode};
endfunction

function automatic word_t j_type(input logic [20:0] imm, input reg_idx_t rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
endfunction

function automatic word_t load_word(input reg_idx_t rd, input reg_idx_t rs1,
                                    input logic [11:0] imm);
  return i_type(imm, rs1, 3'b010, rd, opc_load);
endfunction

function automatic word_t store_word(input reg_idx_t rs2, input reg_idx_t rs1,
                                     input logic [11:0] imm);
  return s_type(imm, rs2, rs1, 3'b010);
endfunction

`endif

/* testbench/tb_rv_core.sv */
/*
 * Testbench for the RV32I single-cycle core.
 * Clock, reset, instruction ROM and data RAM models, LFSR operands,
 * compare tasks and directed program tests.
 */

`timescale 1ns/10ps
`default_nettype none

module tb_rv_core
  import rv_pkg::*;
();

  localparam int    mem_words   = 64;
  localparam word_t marker_addr = 32'h0000_00FC;
  localparam int    wait_limit  = 400;
  localparam word_t poison      = 32'hBAD0_BAD0;

  logic  clock = 1'b0;
  logic  rst_n = 1'b0;
  word_t pc;
  word_t inst;
  word_t data_mem_address;
  word_t data_mem_write_data;
  logic  data_mem_write_enable;
  word_t data_mem_read_data;

  word_t prog [mem_words];
  word_t dmem [mem_words];
  word_t dmem_init [mem_words];
  word_t code [$];
  int    exp_slot [$];
  word_t exp_val [$];
  // Branch and jump pc mapped to the pc expected one cycle later
  word_t next_after [word_t];
  logic  branch_pending = 1'b0;
  word_t branch_expect;
  word_t lfsr_state = 32'd10;
  int    check_count = 0;
  int    error_count = 0;
  int    timeout_count = 0;

  `include "rv_asm.svh"

  always #10 clock = ~clock;

  rv_core u_dut (
    .clock                 (clock),
    .rst_n                 (rst_n),
    .pc                    (pc),
    .inst                  (inst),
    .data_mem_address      (data_mem_address),
    .data_mem_write_data   (data_mem_write_data),
    .data_mem_write_enable (data_mem_write_enable),
    .data_mem_read_data    (data_mem_read_data)
  );

  // --------------------------------------------------------------------------
  // Memory models
  // --------------------------------------------------------------------------
  assign inst               = (pc[31:8] == '0) ? prog[pc[7:2]] : nop_inst;
  assign data_mem_read_data = dmem[data_mem_address[7:2]];

  // RAM reloads its initial image while the core is in reset
  always @(posedge clock) begin
    if (!rst_n) begin
      dmem <= dmem_init;
    end else if (data_mem_write_enable) begin
      dmem[data_mem_address[7:2]] <= data_mem_write_data;
    end
  end

  // Pc one cycle after each branch or jump
  always @(negedge clock) begin
    if (rst_n && branch_pending) begin
      check_pc(pc, branch_expect);
      branch_pending = 1'b0;
    end
    if (rst_n && next_after.exists(pc)) begin
      branch_expect  = next_after[pc];
      branch_pending = 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Random numbers and reference results
  // --------------------------------------------------------------------------
  function automatic logic next_lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic word_t random_bits(input int count);
    word_t value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], next_lfsr_bit()};
    end
    return value;
  endfunction

  function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // RV32I result for an OP funct3 with alt marking sub and sra
  function automatic word_t rv_result(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
    word_t shifted;
    case (f3)
      f3_add_sub: return alt ? a - b : a + b;
      f3_sll:     return a << b[4:0];
      f3_slt:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      f3_sltu:    return (a < b) ? 32'd1 : 32'd0;
      f3_xor:     return a ^ b;
      f3_srl_sra: begin
        shifted = a >> b[4:0];
        if (alt && a[31]) begin
          shifted = shifted | ~(32'hFFFF_FFFF >> b[4:0]);
        end
        return shifted;
      end
      f3_or:      return a | b;
      default:    return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] cond, input word_t a,
                                        input word_t b);
    case (cond)
      f3_beq:  return a == b;
      f3_bne:  return a != b;
      f3_blt:  return $signed(a) < $signed(b);
      f3_bge:  return $signed(a) >= $signed(b);
      f3_bltu: return a < b;
      f3_bgeu: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic check_word(input string name, input word_t got, input word_t want);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("Fail %0t %s got %08h expected %08h", $time, name, got, want);
    end
  endtask

  task automatic check_pc(input word_t got, input word_t want);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("Fail %0t pc got %08h expected %08h", $time, got, want);
    end
  endtask

  // --------------------------------------------------------------------------
  // Program building and running
  // --------------------------------------------------------------------------
  function automatic word_t current_pc();
    return word_t'(code.size() * 4);
  endfunction

  task automatic emit_li(input reg_idx_t rd, input word_t value);
    word_t upper;
    // Rounding covers the sign extension of the ADDI immediate
    upper = value + 32'h800;
    code.push_back(u_type(upper[31:12], rd, opc_lui));
    code.push_back(i_type(value[11:0], rd, f3_add_sub, rd, opc_op_imm));
  endtask

  task automatic emit_store(input reg_idx_t rs2, input int slot);
    code.push_back(store_word(rs2, 5'd0, 12'(slot * 4)));
  endtask

  task automatic expect_store(input int slot, input word_t value);
    exp_slot.push_back(slot);
    exp_val.push_back(value);
  endtask

  task automatic begin_test(input string title);
    @(posedge clock);
    rst_n <= 1'b0;
    code.delete();
    exp_slot.delete();
    exp_val.delete();
    next_after.delete();
    for (int i = 0; i < mem_words; i++) begin
      dmem_init[i] = 32'hF11C_0000 ^ word_t'(i * 4);
    end
    $display("Running %s", title);
  endtask

  task automatic run_program();
    int cycles;
    // Marker store followed by a spin in place
    code.push_back(store_word(5'd0, 5'd0, marker_addr[11:0]));
    code.push_back(j_type(21'd0, 5'd0));
    for (int i = 0; i < mem_words; i++) begin
      prog[i] = (i < code.size()) ? code[i] : nop_inst;
    end
    for (int i = 0; i < 8; i++) begin
      @(negedge clock);
      if (i > 0) begin
        check_pc(pc, initial_pc);
      end
      check_count++;
      if (data_mem_write_enable !== 1'b0) begin
        error_count++;
        $display("Fail %0t data_mem_write_enable got %b expected 0", $time,
                 data_mem_write_enable);
      end
    end
    @(posedge clock);
    rst_n <= 1'b1;
    @(negedge clock);
    check_pc(pc, initial_pc);
    cycles = 0;
    while (!(data_mem_write_enable && data_mem_address == marker_addr) &&
           cycles < wait_limit) begin
      @(negedge clock);
      cycles++;
    end
    if (cycles >= wait_limit) begin
      timeout_count++;
      $display("Timeout: no store to the marker address within %0d cycles", wait_limit);
    end else begin
      @(negedge clock);
      foreach (exp_slot[i]) begin
        check_word($sformatf("dmem[%0d]", exp_slot[i]), dmem[exp_slot[i]], exp_val[i]);
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic test_alu_ops();
    word_t       a;
    word_t       b;
    word_t       rnd;
    logic [11:0] imm;
    logic [2:0]  f3;
    int          slot;
    begin_test("ALU operations");
    // Store at the reset address keeps a write decoded throughout reset
    emit_store(5'd0, 20);
    expect_store(20, 32'd0);
    a = random_bits(32);
    b = random_bits(32);
    emit_li(5'd1, a);
    emit_li(5'd2, b);
    slot = 0;
    for (int f = 0; f < 8; f++) begin
      f3 = f[2:0];
      code.push_back(r_type(7'b0, 5'd2, 5'd1, f3, 5'd3, opc_op));
      emit_store(5'd3, slot);
      expect_store(slot, rv_result(f3, 1'b0, a, b));
      slot++;
      rnd = random_bits(12);
      imm = (f3 == f3_sll || f3 == f3_srl_sra) ? {7'b0, rnd[4:0]} : rnd[11:0];
      code.push_back(i_type(imm, 5'd1, f3, 5'd4, opc_op_imm));
      emit_store(5'd4, slot);
      expect_store(slot, rv_result(f3, 1'b0, a, sext12(imm)));
      slot++;
    end
    // Alternate forms sub, sra and srai
    code.push_back(r_type(7'b0100000, 5'd2, 5'd1, f3_add_sub, 5'd3, opc_op));
    emit_store(5'd3, slot);
    expect_store(slot, rv_result(f3_add_sub, 1'b1, a, b));
    slot++;
    code.push_back(r_type(7'b0100000, 5'd2, 5'd1, f3_srl_sra, 5'd3, opc_op));
    emit_store(5'd3, slot);
    expect_store(slot, rv_result(f3_srl_sra, 1'b1, a, b));
    slot++;
    rnd = random_bits(5);
    imm = {7'b0100000, rnd[4:0]};
    code.push_back(i_type(imm, 5'd1, f3_srl_sra, 5'd4, opc_op_imm));
    emit_store(5'd4, slot);
    expect_store(slot, rv_result(f3_srl_sra, 1'b1, a, {27'b0, rnd[4:0]}));
    run_program();
  endtask

  task automatic test_loads_upper();
    word_t upper;
    word_t upc;
    begin_test("loads and upper immediates");
    for (int i = 0; i < 8; i++) begin
      dmem_init[i] = random_bits(32);
    end
    // Base of 8 puts the first offsets below zero
    code.push_back(i_type(12'd8, 5'd0, f3_add_sub, 5'd4, opc_op_imm));
    for (int i = 0; i < 8; i++) begin
      code.push_back(load_word(5'd5, 5'd4, 12'(i * 4 - 8)));
      emit_store(5'd5, 16 + i);
      expect_store(16 + i, dmem_init[i]);
    end
    upper = random_bits(20);
    code.push_back(u_type(upper[19:0], 5'd6, opc_lui));
    emit_store(5'd6, 32);
    expect_store(32, {upper[19:0], 12'b0});
    upper = random_bits(20);
    upc = current_pc();
    code.push_back(u_type(upper[19:0], 5'd7, opc_auipc));
    emit_store(5'd7, 33);
    expect_store(33, upc + {upper[19:0], 12'b0});
    run_program();
  endtask

  task automatic test_branches();
    logic [2:0] conds [6];
    word_t      a;
    word_t      b;
    word_t      bpc;
    word_t      va;
    word_t      vb;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic       taken;
    int         slot;
    begin_test("branches");
    conds = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
    // Opposite signs so signed and unsigned compares disagree
    a = random_bits(32) | 32'h8000_0000;
    b = random_bits(32) & 32'h7FFF_FFFF;
    emit_li(5'd10, a);
    emit_li(5'd11, b);
    emit_li(5'd12, poison);
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        rs1   = (p == 2) ? 5'd11 : 5'd10;
        rs2   = (p == 1) ? 5'd11 : 5'd10;
        va    = (rs1 == 5'd11) ? b : a;
        vb    = (rs2 == 5'd11) ? b : a;
        taken = branch_taken(conds[c], va, vb);
        slot  = 40 + c * 3 + p;
        bpc   = current_pc();
        code.push_back(b_type(13'd8, rs2, rs1, conds[c]));
        emit_store(5'd12, slot);
        next_after[bpc] = taken ? bpc + 32'd8 : bpc + 32'd4;
        expect_store(slot, taken ? dmem_init[slot] : poison);
      end
    end
    run_program();
  endtask

  task automatic test_jumps_x0();
    word_t jpc;
    begin_test("jumps and x0");
    emit_li(5'd12, poison);
    jpc = current_pc();
    code.push_back(j_type(21'd8, 5'd1));
    emit_store(5'd12, 60);
    expect_store(60, dmem_init[60]);
    next_after[jpc] = jpc + 32'd8;
    emit_store(5'd1, 58);
    expect_store(58, jpc + 32'd4);
    // Odd base plus 4 lands one byte past the target
    jpc = current_pc();
    code.push_back(i_type(12'(jpc + 32'd9), 5'd0, f3_add_sub, 5'd5, opc_op_imm));
    code.push_back(i_type(12'd4, 5'd5, 3'b000, 5'd6, opc_jalr));
    emit_store(5'd12, 61);
    expect_store(61, dmem_init[61]);
    next_after[jpc + 32'd4] = jpc + 32'd12;
    emit_store(5'd6, 59);
    expect_store(59, jpc + 32'd8);
    code.push_back(i_type(12'h07B, 5'd0, f3_add_sub, 5'd0, opc_op_imm));
    code.push_back(u_type(20'hABCDE, 5'd0, opc_lui));
    emit_store(5'd0, 62);
    expect_store(62, 32'd0);
    run_program();
  endtask

  initial begin
    test_alu_ops();
    test_alu_ops();
    test_loads_upper();
    test_branches();
    test_jumps_x0();
    $display("Checks: %0d  errors: %0d  timeouts: %0d", check_count, error_count,
             timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
